// File: common/rob_except_macros.svh
/* rob exception bank sizing
   lane, bundle and writeback port counts shared by RTL and testbench */

`ifndef ROB_EXCEPT_MACROS_SVH
`define ROB_EXCEPT_MACROS_SVH

// instruction lanes per reorder buffer bundle
`define ROBX_LANES 4

// bundles held by the reorder buffer
`define ROBX_BUNDLES 48

// writeback ports that can report an exception per cycle
`define ROBX_WB_PORTS 3

`endif

// File: common/rob_except_pkg.sv
/* rob exception bank types
   vector typedefs for bundle, lane, tag and exception code */

`include "rob_except_macros.svh"

package rob_except_pkg;

  // bundle number, only 0 to ROBX_BUNDLES-1 are legal
  typedef logic [$clog2(`ROBX_BUNDLES)-1:0] bundle_idx_t;

  typedef logic [$clog2(`ROBX_LANES)-1:0] lane_idx_t; // lane within a bundle

  // tag is the bundle index on top and the lane index below it
  typedef logic [$bits(bundle_idx_t)+$bits(lane_idx_t)-1:0] rob_tag_t;

  // exception cause, zero means the lane did not except
  typedef logic [7:0] except_code_t;

endpackage

// File: rob_except/wb_router.sv
/* writeback router for the rob exception bank
   splits tags into bundle and lane strobes and registers every write for one stage */

`timescale 1ns/100ps
`include "rob_except_macros.svh"

module wb_router (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 wb0_wen,
  input  rob_except_pkg::rob_tag_t                             wb0_tag,
  input  rob_except_pkg::except_code_t                         wb0_code,
  input  logic                                                 wb1_wen,
  input  rob_except_pkg::rob_tag_t                             wb1_tag,
  input  rob_except_pkg::except_code_t                         wb1_code,
  input  logic                                                 wb2_wen,
  input  rob_except_pkg::rob_tag_t                             wb2_tag,
  input  rob_except_pkg::except_code_t                         wb2_code,
  input  logic                                                 init_wen,
  input  rob_except_pkg::bundle_idx_t                          init_bundle,
  input  rob_except_pkg::except_code_t                         init_code0,
  input  rob_except_pkg::except_code_t                         init_code1,
  input  rob_except_pkg::except_code_t                         init_code2,
  input  rob_except_pkg::except_code_t                         init_code3,
  output logic [`ROBX_LANES-1:0][`ROBX_WB_PORTS-1:0]           lane_wen,
  output rob_except_pkg::bundle_idx_t [`ROBX_WB_PORTS-1:0]     port_bundle,
  output rob_except_pkg::except_code_t [`ROBX_WB_PORTS-1:0]    port_code,
  output logic                                                 init_wen_q,
  output rob_except_pkg::bundle_idx_t                          init_bundle_q,
  output rob_except_pkg::except_code_t [`ROBX_LANES-1:0]       init_code_q
);
  import rob_except_pkg::*;

  localparam int LANE_W = $bits(lane_idx_t);
  localparam int TAG_W = $bits(rob_tag_t);

  logic [`ROBX_WB_PORTS-1:0]                 wb_wen;
  rob_tag_t [`ROBX_WB_PORTS-1:0]             wb_tag;
  except_code_t [`ROBX_WB_PORTS-1:0]         wb_code;
  bundle_idx_t [`ROBX_WB_PORTS-1:0]          wb_bundle;
  lane_idx_t [`ROBX_WB_PORTS-1:0]            wb_lane;
  except_code_t [`ROBX_LANES-1:0]            init_code_d;
  logic [`ROBX_LANES-1:0][`ROBX_WB_PORTS-1:0] lane_wen_d;

  // port 0 and lane 0 sit in the low element
  assign wb_wen = {wb2_wen, wb1_wen, wb0_wen};
  assign wb_tag = {wb2_tag, wb1_tag, wb0_tag};
  assign wb_code = {wb2_code, wb1_code, wb0_code};
  assign init_code_d = {init_code3, init_code2, init_code1, init_code0};

  always_comb begin
    for (int p = 0; p < `ROBX_WB_PORTS; p++) begin
      wb_bundle[p] = wb_tag[p][TAG_W-1:LANE_W];
      wb_lane[p] = wb_tag[p][LANE_W-1:0];
    end
    for (int k = 0; k < `ROBX_LANES; k++) begin
      for (int p = 0; p < `ROBX_WB_PORTS; p++) begin
        lane_wen_d[k][p] = wb_wen[p] && (wb_lane[p] == lane_idx_t'(k)); // only the tagged lane
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_wen <= '0;
      init_wen_q <= 1'b0;
    end else begin
      lane_wen <= lane_wen_d;
      init_wen_q <= init_wen;
    end
  end

  always_ff @(posedge clk) begin
    port_bundle <= wb_bundle;
    port_code <= wb_code;
    init_bundle_q <= init_bundle;
    init_code_q <= init_code_d;
  end

  // a write that leaves the router must address a bundle that exists
  for (genvar p = 0; p < `ROBX_WB_PORTS; p++) begin : g_wb_chk
    a_wb_bundle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_wen[p] |=> port_bundle[p] < `ROBX_BUNDLES)
      else $error("writeback port %0d wrote bundle %0d", p, port_bundle[p]);
  end

  a_init_bundle: assert property (@(posedge clk) disable iff (!rst_n)
    init_wen |=> init_bundle_q < `ROBX_BUNDLES)
    else $error("init wrote bundle %0d", init_bundle_q);

endmodule

// File: rob_except/except_lane_ram.sv
/* exception code RAM for one lane
   one write per writeback port plus init, read through a latched bundle index */

`timescale 1ns/100ps
`include "rob_except_macros.svh"

module except_lane_ram (
  input  logic                                              clk,
  input  logic [`ROBX_WB_PORTS-1:0]                         lane_wen,
  input  rob_except_pkg::bundle_idx_t [`ROBX_WB_PORTS-1:0]  port_bundle,
  input  rob_except_pkg::except_code_t [`ROBX_WB_PORTS-1:0] port_code,
  input  logic                                              init_wen,
  input  rob_except_pkg::bundle_idx_t                       init_bundle,
  input  rob_except_pkg::except_code_t                      init_code,
  input  logic                                              read_step,
  input  rob_except_pkg::bundle_idx_t                       read_bundle,
  output rob_except_pkg::except_code_t                      read_code
);
  import rob_except_pkg::*;

  except_code_t ram [0:`ROBX_BUNDLES-1];
  bundle_idx_t  read_idx;

  // later writes override earlier ones to the same entry,
  // so the highest port wins and init beats every port
  always_ff @(posedge clk) begin
    for (int p = 0; p < `ROBX_WB_PORTS; p++) begin
      if (lane_wen[p]) begin
        ram[port_bundle[p]] <= port_code[p];
      end
    end
    if (init_wen) begin
      ram[init_bundle] <= init_code;
    end
  end

  always_ff @(posedge clk) begin
    if (read_step) begin
      read_idx <= read_bundle; // held until the core steps again
    end
  end

  assign read_code = ram[read_idx];

  // the latched index addresses a real entry for the whole read window
  a_read_bundle: assert property (@(posedge clk)
    read_step |=> read_idx < `ROBX_BUNDLES)
    else $error("read stepped to bundle %0d", read_idx);

endmodule

// File: rob_except/retire_scanner.sv
/* retire scanner for the rob exception bank
   finds the lowest excepting lane of the stepped bundle and registers the summary */

`timescale 1ns/100ps
`include "rob_except_macros.svh"

module retire_scanner (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        read_step,
  input  rob_except_pkg::except_code_t [`ROBX_LANES-1:0] lane_code,
  output logic                                        retire_valid,
  output logic                                        retire_except,
  output rob_except_pkg::lane_idx_t                   retire_lane,
  output rob_except_pkg::except_code_t                retire_code
);
  import rob_except_pkg::*;

  logic         step_q; // lane codes belong to a fresh step this cycle
  logic         found;
  lane_idx_t    found_lane;
  except_code_t found_code;

  // scan from the top lane down so the lowest nonzero lane is kept last
  always_comb begin
    found = 1'b0;
    found_lane = '0;
    found_code = '0;
    for (int k = `ROBX_LANES - 1; k >= 0; k--) begin
      if (lane_code[k] != '0) begin
        found = 1'b1;
        found_lane = lane_idx_t'(k);
        found_code = lane_code[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step_q <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      step_q <= read_step;
      retire_valid <= step_q; // one pulse per step, back to back when stepping every cycle
    end
  end

  always_ff @(posedge clk) begin
    if (step_q) begin
      retire_except <= found;
      retire_lane <= found_lane;
      retire_code <= found_code;
    end
  end

  // a reported exception always carries its cause
  a_except_code: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && retire_except |-> retire_code != '0)
    else $error("retire reported lane %0d with a zero code", retire_lane);

endmodule

// File: verilog/rob_except_top.sv
/* rob exception record bank
   writeback router, one code RAM per lane and the retire summary scanner */

`timescale 1ns/100ps
`include "rob_except_macros.svh"

module rob_except_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wb0_wen,
  input  rob_except_pkg::rob_tag_t     wb0_tag,
  input  rob_except_pkg::except_code_t wb0_code,
  input  logic                         wb1_wen,
  input  rob_except_pkg::rob_tag_t     wb1_tag,
  input  rob_except_pkg::except_code_t wb1_code,
  input  logic                         wb2_wen,
  input  rob_except_pkg::rob_tag_t     wb2_tag,
  input  rob_except_pkg::except_code_t wb2_code,
  input  logic                         init_wen,
  input  rob_except_pkg::bundle_idx_t  init_bundle,
  input  rob_except_pkg::except_code_t init_code0,
  input  rob_except_pkg::except_code_t init_code1,
  input  rob_except_pkg::except_code_t init_code2,
  input  rob_except_pkg::except_code_t init_code3,
  input  logic                         read_step,
  input  rob_except_pkg::bundle_idx_t  read_bundle,
  output rob_except_pkg::except_code_t read_code0,
  output rob_except_pkg::except_code_t read_code1,
  output rob_except_pkg::except_code_t read_code2,
  output rob_except_pkg::except_code_t read_code3,
  output logic                         retire_valid,
  output logic                         retire_except,
  output rob_except_pkg::lane_idx_t    retire_lane,
  output rob_except_pkg::except_code_t retire_code
);
  import rob_except_pkg::*;

  logic [`ROBX_LANES-1:0][`ROBX_WB_PORTS-1:0] lane_wen;
  bundle_idx_t [`ROBX_WB_PORTS-1:0]           port_bundle;
  except_code_t [`ROBX_WB_PORTS-1:0]          port_code;
  logic                                       init_wen_q;
  bundle_idx_t                                init_bundle_q;
  except_code_t [`ROBX_LANES-1:0]             init_code_q;
  except_code_t [`ROBX_LANES-1:0]             lane_read_code;

  wb_router u_wb_router (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb0_wen       (wb0_wen),
    .wb0_tag       (wb0_tag),
    .wb0_code      (wb0_code),
    .wb1_wen       (wb1_wen),
    .wb1_tag       (wb1_tag),
    .wb1_code      (wb1_code),
    .wb2_wen       (wb2_wen),
    .wb2_tag       (wb2_tag),
    .wb2_code      (wb2_code),
    .init_wen      (init_wen),
    .init_bundle   (init_bundle),
    .init_code0    (init_code0),
    .init_code1    (init_code1),
    .init_code2    (init_code2),
    .init_code3    (init_code3),
    .lane_wen      (lane_wen),
    .port_bundle   (port_bundle),
    .port_code     (port_code),
    .init_wen_q    (init_wen_q),
    .init_bundle_q (init_bundle_q),
    .init_code_q   (init_code_q)
  );

  // each lane RAM sees every port but only its own strobes
  for (genvar k = 0; k < `ROBX_LANES; k++) begin : g_lane
    except_lane_ram u_lane_ram (
      .clk         (clk),
      .lane_wen    (lane_wen[k]),
      .port_bundle (port_bundle),
      .port_code   (port_code),
      .init_wen    (init_wen_q),
      .init_bundle (init_bundle_q),
      .init_code   (init_code_q[k]),
      .read_step   (read_step),
      .read_bundle (read_bundle),
      .read_code   (lane_read_code[k])
    );
  end

  retire_scanner u_retire_scanner (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_step     (read_step),
    .lane_code     (lane_read_code),
    .retire_valid  (retire_valid),
    .retire_except (retire_except),
    .retire_lane   (retire_lane),
    .retire_code   (retire_code)
  );

  assign read_code0 = lane_read_code[0];
  assign read_code1 = lane_read_code[1];
  assign read_code2 = lane_read_code[2];
  assign read_code3 = lane_read_code[3];

endmodule

// File: tests/tb_rob_except.sv
/* testbench for the rob exception record bank
   directed tests against a reference code model, with read and retire summary checks */

`timescale 1ns/100ps
`include "rob_except_macros.svh"

module tb_rob_except;
  import rob_except_pkg::*;

  logic         clk;
  logic         rst_n;
  logic         wb0_wen;
  rob_tag_t     wb0_tag;
  except_code_t wb0_code;
  logic         wb1_wen;
  rob_tag_t     wb1_tag;
  except_code_t wb1_code;
  logic         wb2_wen;
  rob_tag_t     wb2_tag;
  except_code_t wb2_code;
  logic         init_wen;
  bundle_idx_t  init_bundle;
  except_code_t init_code0;
  except_code_t init_code1;
  except_code_t init_code2;
  except_code_t init_code3;
  logic         read_step;
  bundle_idx_t  read_bundle;
  except_code_t read_code0;
  except_code_t read_code1;
  except_code_t read_code2;
  except_code_t read_code3;
  logic         retire_valid;
  logic         retire_except;
  lane_idx_t    retire_lane;
  except_code_t retire_code;

  except_code_t model [0:`ROBX_BUNDLES-1][0:`ROBX_LANES-1]; // expected contents of every entry
  int errors;
  int checks;

  rob_except_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_writes();
    wb0_wen = 1'b0;
    wb1_wen = 1'b0;
    wb2_wen = 1'b0;
    init_wen = 1'b0;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic set_wb(input int port, input rob_tag_t tag, input except_code_t code);
    case (port)
      0: begin
        wb0_wen = 1'b1;
        wb0_tag = tag;
        wb0_code = code;
      end
      1: begin
        wb1_wen = 1'b1;
        wb1_tag = tag;
        wb1_code = code;
      end
      default: begin
        wb2_wen = 1'b1;
        wb2_tag = tag;
        wb2_code = code;
      end
    endcase
  endtask

  task automatic set_init(input bundle_idx_t b, input except_code_t c0, input except_code_t c1,
                          input except_code_t c2, input except_code_t c3);
    init_wen = 1'b1;
    init_bundle = b;
    init_code0 = c0;
    init_code1 = c1;
    init_code2 = c2;
    init_code3 = c3;
    model[b][0] = c0;
    model[b][1] = c1;
    model[b][2] = c2;
    model[b][3] = c3;
  endtask

  // lets the last registered writes land before any read
  task automatic settle();
    next_cycle();
    clear_writes();
    next_cycle();
    next_cycle();
  endtask

  task automatic wait_retire(output bit seen);
    seen = 1'b0;
    for (int i = 0; i < 10 && !seen; i++) begin
      @(negedge clk);
      if (retire_valid === 1'b1) seen = 1'b1;
    end
  endtask

  task automatic check_read_codes(input bundle_idx_t b);
    compare("read_code0", read_code0, model[b][0]);
    compare("read_code1", read_code1, model[b][1]);
    compare("read_code2", read_code2, model[b][2]);
    compare("read_code3", read_code3, model[b][3]);
  endtask

  task automatic check_summary(input bundle_idx_t b);
    bit           exp_except;
    lane_idx_t    exp_lane;
    except_code_t exp_code;
    exp_except = 1'b0;
    exp_lane = '0;
    exp_code = '0;
    for (int k = 0; k < `ROBX_LANES; k++) begin
      if (!exp_except && model[b][k] != '0) begin
        exp_except = 1'b1; // first excepting lane counting up from lane 0
        exp_lane = lane_idx_t'(k);
        exp_code = model[b][k];
      end
    end
    compare("retire_except", retire_except, exp_except);
    if (exp_except) begin
      compare("retire_lane", retire_lane, exp_lane);
      compare("retire_code", retire_code, exp_code);
    end
  endtask

  task automatic read_one(input bundle_idx_t b);
    bit seen;
    next_cycle();
    read_step = 1'b1;
    read_bundle = b;
    next_cycle();
    read_step = 1'b0;
    @(negedge clk);
    check_read_codes(b);
    wait_retire(seen);
    if (!seen) begin
      errors++;
      $display("timed out waiting for retire_valid after reading bundle %0d", b);
    end else begin
      check_summary(b);
    end
  endtask

  // one read_step per cycle while a second process collects the summaries in order
  task automatic pipelined_reads(input bundle_idx_t list[$]);
    int n;
    n = list.size();
    fork
      begin
        for (int i = 0; i <= n; i++) begin
          next_cycle();
          if (i < n) begin
            read_step = 1'b1;
            read_bundle = list[i];
          end else begin
            read_step = 1'b0;
          end
          @(negedge clk);
          if (i > 0) check_read_codes(list[i-1]);
        end
      end
      begin
        bit seen;
        bit lost;
        lost = 1'b0;
        for (int i = 0; i < n && !lost; i++) begin
          wait_retire(seen);
          if (!seen) begin
            lost = 1'b1;
            errors++;
            $display("timed out waiting for retire summary %0d of %0d", i + 1, n);
          end else begin
            check_summary(list[i]);
          end
        end
      end
    join
  endtask

  task automatic test_reset();
    repeat (5) begin
      @(negedge clk);
      compare("retire_valid", retire_valid, 1'b0);
    end
  endtask

  task automatic test_init_clean();
    bundle_idx_t list[$];
    for (int b = 0; b < `ROBX_BUNDLES; b++) begin
      next_cycle();
      set_init(bundle_idx_t'(b), '0, '0, '0, '0);
      list.push_back(bundle_idx_t'(b));
    end
    settle();
    pipelined_reads(list);
  endtask

  task automatic test_single_wb();
    bundle_idx_t  b;
    lane_idx_t    l;
    except_code_t code;
    int           port;
    repeat (16) begin
      next_cycle();
      clear_writes();
      b = bundle_idx_t'($urandom % `ROBX_BUNDLES);
      l = lane_idx_t'($urandom % `ROBX_LANES);
      code = except_code_t'($urandom_range(255, 1));
      port = $urandom % `ROBX_WB_PORTS;
      set_wb(port, rob_tag_t'({b, l}), code);
      model[b][l] = code;
    end
    settle();
    for (int k = 0; k < `ROBX_BUNDLES; k++) read_one(bundle_idx_t'(k));
  endtask

  task automatic test_priority();
    bundle_idx_t b;
    bundle_idx_t b1;
    bundle_idx_t b2;
    b = bundle_idx_t'($urandom % `ROBX_BUNDLES);
    b1 = bundle_idx_t'((b + 1) % `ROBX_BUNDLES);
    b2 = bundle_idx_t'((b + 2) % `ROBX_BUNDLES);
    next_cycle();
    clear_writes();
    set_wb(0, rob_tag_t'({b, 2'd1}), 8'h21);
    set_wb(1, rob_tag_t'({b, 2'd1}), 8'h42);
    set_wb(2, rob_tag_t'({b, 2'd1}), 8'h63);
    model[b][1] = 8'h63; // port 2 is the highest writer
    next_cycle();
    clear_writes();
    set_wb(0, rob_tag_t'({b1, 2'd3}), 8'h5a);
    set_wb(1, rob_tag_t'({b1, 2'd3}), 8'ha5);
    model[b1][3] = 8'ha5;
    next_cycle();
    clear_writes();
    set_wb(2, rob_tag_t'({b2, 2'd2}), 8'h77);
    set_init(b2, 8'h00, 8'h00, 8'h19, 8'h00); // init overrides the writeback on lane 2
    settle();
    read_one(b);
    read_one(b1);
    read_one(b2);
  endtask

  task automatic test_parallel_lanes();
    bundle_idx_t b;
    b = bundle_idx_t'($urandom % `ROBX_BUNDLES);
    next_cycle();
    clear_writes();
    set_init(b, '0, '0, '0, '0);
    next_cycle();
    clear_writes();
    set_wb(0, rob_tag_t'({b, 2'd3}), except_code_t'($urandom_range(255, 1)));
    set_wb(1, rob_tag_t'({b, 2'd1}), except_code_t'($urandom_range(255, 1)));
    set_wb(2, rob_tag_t'({b, 2'd2}), except_code_t'($urandom_range(255, 1)));
    model[b][3] = wb0_code;
    model[b][1] = wb1_code;
    model[b][2] = wb2_code;
    settle();
    read_one(b);
    compare("retire_lane", retire_lane, 2'd1);
  endtask

  task automatic test_pipelined();
    bundle_idx_t  list[$];
    bundle_idx_t  b;
    bundle_idx_t  start;
    lane_idx_t    l;
    except_code_t code;
    start = bundle_idx_t'($urandom % `ROBX_BUNDLES);
    for (int i = 0; i < 12; i++) begin
      b = bundle_idx_t'((start + 5 * i) % `ROBX_BUNDLES); // 5 and 48 share no factor
      l = lane_idx_t'($urandom % `ROBX_LANES);
      code = except_code_t'($urandom_range(255, 1));
      next_cycle();
      clear_writes();
      set_wb(i % `ROBX_WB_PORTS, rob_tag_t'({b, l}), code);
      model[b][l] = code;
      list.push_back(b);
    end
    settle();
    pipelined_reads(list);
  endtask

  initial begin
    void'($urandom(841));
    errors = 0;
    checks = 0;
    rst_n = 1'b0;
    clear_writes();
    wb0_tag = '0;
    wb0_code = '0;
    wb1_tag = '0;
    wb1_code = '0;
    wb2_tag = '0;
    wb2_code = '0;
    init_bundle = '0;
    init_code0 = '0;
    init_code1 = '0;
    init_code2 = '0;
    init_code3 = '0;
    read_step = 1'b0;
    read_bundle = '0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    test_reset();
    test_init_clean();
    test_single_wb();
    test_priority();
    test_parallel_lanes();
    test_pipelined();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+common
common/rob_except_pkg.sv
rob_except/wb_router.sv
rob_except/except_lane_ram.sv
rob_except/retire_scanner.sv
verilog/rob_except_top.sv
tests/tb_rob_except.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the rob exception bank testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir_tb
SIM_BIN=sim_tb
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f flist.f --top-module tb_rob_except \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if [ ! -s "$LOG" ]; then
  echo "simulation log is empty"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

exit 0
